// File: files.f
+incdir+src
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/core_stage_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_io_stage.sv
src/rv_core_top.sv
testbench/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -f files.f --top-module tb_rv_core -o tb_rv_core \
    && ./obj_dir/tb_rv_core | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ------------------------------
// memory sizes, in 32-bit words
// ------------------------------
`define CFG_IMEM_DEPTH      256
`define CFG_DMEM_DEPTH      256

// ------------------------------
// io map
// ------------------------------
// everything at or above the base decodes as io
`define CFG_IO_BASE         32'hFFFF_F000
`define CFG_IO_SWITCH_ADDR  32'hFFFF_FFF0
`define CFG_IO_LED_ADDR     32'hFFFF_FFE0

// first fetch address after reset
`define CFG_RESET_PC        32'h0000_0000

`endif

// File: src/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    // source of the register file write data
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_src_e;

    // per-instruction datapath controls
    typedef struct packed {
        logic                reg_write;
        logic                alu_src_imm;
        rv_isa_pkg::alu_op_e alu_op;
        logic                mem_read;
        logic                mem_write;
        logic                branch;
        logic                branch_ne;   // bne when set, beq otherwise
        logic                jump;
        logic                halt;
        wb_src_e             wb_src;
    } ctrl_t;

endpackage

`default_nettype wire

// File: src/core_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction and its operands
interface operand_if;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    pc_plus4;
    rv_isa_pkg::word_t    rs1_val;
    rv_isa_pkg::word_t    rs2_val;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::reg_idx_t rd;
    core_ctrl_pkg::ctrl_t ctrl;

    modport src (output pc, pc_plus4, rs1_val, rs2_val, imm, rd, ctrl);
    modport dst (input  pc, pc_plus4, rs1_val, rs2_val, imm, rd, ctrl);
endinterface

// alu result and pc redirect
interface exec_if;
    rv_isa_pkg::word_t alu_result;
    logic              redirect;
    rv_isa_pkg::word_t redirect_target;

    modport src (output alu_result, redirect, redirect_target);
    modport dst (input  alu_result, redirect, redirect_target);
endinterface

// register file write port
interface writeback_if;
    logic                 we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;

    modport src (output we, rd, data);
    modport dst (input  we, rd, data);
endinterface

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rstn_fpga,
    input  rv_isa_pkg::word_t pc_i,
    input  rv_isa_pkg::word_t instr_i,
    writeback_if.dst          wb_i,
    operand_if.src            op_o
);

    rv_isa_pkg::word_t    regs [32];
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::funct7_t  funct7;
    core_ctrl_pkg::ctrl_t ctrl;
    rv_isa_pkg::word_t    imm;

    assign rs1_idx = instr_i[19:15];
    assign rs2_idx = instr_i[24:20];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];

    // ------------------------------
    // control and immediate
    // ------------------------------
    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (instr_i[6:0])
            rv_isa_pkg::OPC_OP: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        ctrl.alu_op = funct7[5] ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    end
                    rv_isa_pkg::F3_SLL: ctrl.alu_op = rv_isa_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT: ctrl.alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: ctrl.alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL: ctrl.alu_op = rv_isa_pkg::ALU_SRL;
                    rv_isa_pkg::F3_OR:  ctrl.alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: ctrl.alu_op = rv_isa_pkg::ALU_AND;
                    default:            ctrl.reg_write = 1'b0;
                endcase
                // only sub may use the alt funct7, sra and the rest are dropped
                if (funct7 != rv_isa_pkg::F7_BASE &&
                    !(funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_ADD_SUB)) begin
                    ctrl.reg_write = 1'b0;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // addi only
                ctrl.reg_write   = (funct3 == rv_isa_pkg::F3_ADD_SUB);
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_isa_pkg::OPC_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = rv_isa_pkg::ALU_PASS_B;
                imm = {instr_i[31:12], 12'b0};
            end
            rv_isa_pkg::OPC_LOAD: begin
                ctrl.reg_write   = (funct3 == rv_isa_pkg::F3_WORD);
                ctrl.mem_read    = (funct3 == rv_isa_pkg::F3_WORD);
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_src      = core_ctrl_pkg::WB_MEM;
                imm = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_isa_pkg::OPC_STORE: begin
                ctrl.mem_write   = (funct3 == rv_isa_pkg::F3_WORD);
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // compare by subtraction, zero flag in execute
                ctrl.branch    = (funct3 == rv_isa_pkg::F3_BEQ) ||
                                 (funct3 == rv_isa_pkg::F3_BNE);
                ctrl.branch_ne = (funct3 == rv_isa_pkg::F3_BNE);
                ctrl.alu_op    = rv_isa_pkg::ALU_SUB;
                imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_src    = core_ctrl_pkg::WB_PC4;
                imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                // ebreak halts, ecall falls through as a nop
                ctrl.halt = (instr_i[31:7] == {rv_isa_pkg::SYS_EBREAK, 13'b0});
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // ------------------------------
    // register file
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign op_o.pc       = pc_i;
    assign op_o.pc_plus4 = pc_i + 32'd4;
    assign op_o.rs1_val  = regs[rs1_idx];
    assign op_o.rs2_val  = regs[rs2_idx];
    assign op_o.imm      = imm;
    assign op_o.rd       = instr_i[11:7];
    assign op_o.ctrl     = ctrl;

    // x0 stays zero whatever writeback asks for
    x0_zero_a: assert property (@(posedge clk) disable iff (!rstn_fpga)
        (wb_i.we && wb_i.rd == '0) |=> regs[0] == '0)
        else $error("decode: x0 was written");

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    operand_if.dst op_i,
    exec_if.src    ex_o
);

    rv_isa_pkg::word_t alu_a;
    rv_isa_pkg::word_t alu_b;
    rv_isa_pkg::word_t alu_y;
    logic              zero;
    logic              taken;

    assign alu_a = op_i.rs1_val;
    assign alu_b = op_i.ctrl.alu_src_imm ? op_i.imm : op_i.rs2_val;

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (op_i.ctrl.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_y = alu_a + alu_b;
            rv_isa_pkg::ALU_SUB:    alu_y = alu_a - alu_b;
            rv_isa_pkg::ALU_AND:    alu_y = alu_a & alu_b;
            rv_isa_pkg::ALU_OR:     alu_y = alu_a | alu_b;
            rv_isa_pkg::ALU_XOR:    alu_y = alu_a ^ alu_b;
            rv_isa_pkg::ALU_SLL:    alu_y = alu_a << alu_b[4:0];
            rv_isa_pkg::ALU_SRL:    alu_y = alu_a >> alu_b[4:0];
            rv_isa_pkg::ALU_SLT:    alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_isa_pkg::ALU_PASS_B: alu_y = alu_b;
            default:                alu_y = alu_a + alu_b;
        endcase
    end

    // ------------------------------
    // branch and jump
    // ------------------------------
    // branches run a sub, so zero means rs1 == rs2
    assign zero  = (alu_y == '0);
    assign taken = op_i.ctrl.branch && (op_i.ctrl.branch_ne ? !zero : zero);

    assign ex_o.alu_result      = alu_y;
    assign ex_o.redirect        = taken || op_i.ctrl.jump;
    assign ex_o.redirect_target = op_i.pc + op_i.imm;

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              rstn_fpga,
    input  logic              prog_we_i,
    input  logic [7:0]        prog_addr_i,
    input  rv_isa_pkg::word_t prog_data_i,
    input  logic              halt_i,
    exec_if.dst               exec_i,
    output rv_isa_pkg::word_t pc_o,
    output rv_isa_pkg::word_t instr_o
);

    localparam int IMEM_AW = $clog2(`CFG_IMEM_DEPTH);

    rv_isa_pkg::word_t imem [`CFG_IMEM_DEPTH];
    rv_isa_pkg::word_t pc_q;
    rv_isa_pkg::word_t pc_next;

    // ------------------------------
    // instruction memory
    // ------------------------------
    // load port only while reset is held
    always_ff @(posedge clk) begin
        if (!rstn_fpga && prog_we_i) begin
            imem[prog_addr_i[IMEM_AW-1:0]] <= prog_data_i;
        end
    end

    assign instr_o = imem[pc_q[IMEM_AW+1:2]];

    // ------------------------------
    // program counter
    // ------------------------------
    assign pc_next = exec_i.redirect ? exec_i.redirect_target : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            pc_q <= `CFG_RESET_PC;
        end else if (!halt_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // branch and jump targets come from execute
    pc_aligned_a: assert property (@(posedge clk) disable iff (!rstn_fpga)
        pc_q[1:0] == 2'b00)
        else $error("fetch: pc %h not word aligned", pc_q);

endmodule

`default_nettype wire

// File: src/mem_io_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module mem_io_stage (
    input  logic        clk,
    input  logic        rstn_fpga,
    operand_if.dst      op_i,
    exec_if.dst         ex_i,
    input  logic [15:0] switch_i,
    writeback_if.src    wb_o,
    output logic [15:0] led_o,
    output logic        led_strobe_o,
    output logic        halted_o
);

    localparam int DMEM_AW = $clog2(`CFG_DMEM_DEPTH);

    rv_isa_pkg::word_t dmem [`CFG_DMEM_DEPTH];
    rv_isa_pkg::word_t addr;
    rv_isa_pkg::word_t load_data;
    logic              is_io;
    logic              store_ok;
    logic              dmem_we;
    logic              led_we;
    logic [15:0]       led_q;
    logic              led_strobe_q;
    logic              halted_q;

    // ------------------------------
    // address decode
    // ------------------------------
    assign addr     = ex_i.alu_result;
    assign is_io    = (addr >= `CFG_IO_BASE);
    assign store_ok = rstn_fpga && !halted_q && op_i.ctrl.mem_write;
    assign dmem_we  = store_ok && !is_io;
    assign led_we   = store_ok && (addr == `CFG_IO_LED_ADDR);

    always_comb begin
        if (!op_i.ctrl.mem_read) begin
            load_data = '0;
        end else if (!is_io) begin
            load_data = dmem[addr[DMEM_AW+1:2]];
        end else if (addr == `CFG_IO_SWITCH_ADDR) begin
            load_data = {16'b0, switch_i};
        end else if (addr == `CFG_IO_LED_ADDR) begin
            load_data = {16'b0, led_q};
        end else begin
            load_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[addr[DMEM_AW+1:2]] <= op_i.rs2_val;
        end
    end

    // ------------------------------
    // led register and halt flag
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            led_q        <= '0;
            led_strobe_q <= 1'b0;
            halted_q     <= 1'b0;
        end else begin
            led_strobe_q <= led_we;
            if (led_we) begin
                led_q <= op_i.rs2_val[15:0];
            end
            if (op_i.ctrl.halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    assign led_o        = led_q;
    assign led_strobe_o = led_strobe_q;
    assign halted_o     = halted_q;

    // writeback mux, no register writes once halted
    always_comb begin
        case (op_i.ctrl.wb_src)
            core_ctrl_pkg::WB_MEM: wb_o.data = load_data;
            core_ctrl_pkg::WB_PC4: wb_o.data = op_i.pc_plus4;
            default:               wb_o.data = ex_i.alu_result;
        endcase
    end

    assign wb_o.we = op_i.ctrl.reg_write && !halted_q;
    assign wb_o.rd = op_i.rd;

    // decode never asks for a load and a store at once
    rw_excl_a: assert property (@(posedge clk) disable iff (!rstn_fpga)
        !(op_i.ctrl.mem_read && op_i.ctrl.mem_write))
        else $error("mem_io: mem_read and mem_write both set");

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic        clk,
    input  logic        rstn_fpga,
    input  logic        prog_we_i,
    input  logic [7:0]  prog_addr_i,
    input  logic [31:0] prog_data_i,
    input  logic [15:0] switch_i,
    output logic [15:0] led_o,
    output logic        led_strobe_o,
    output logic        halted_o
);

    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t instr;

    // ------------------------------
    // stage buses
    // ------------------------------
    operand_if   op_bus ();
    exec_if      ex_bus ();
    writeback_if wb_bus ();

    // ------------------------------
    // stages
    // ------------------------------
    fetch_stage u_fetch (
        .clk         (clk),
        .rstn_fpga   (rstn_fpga),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .halt_i      (halted_o),
        .exec_i      (ex_bus),
        .pc_o        (pc),
        .instr_o     (instr)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rstn_fpga (rstn_fpga),
        .pc_i      (pc),
        .instr_i   (instr),
        .wb_i      (wb_bus),
        .op_o      (op_bus)
    );

    execute_stage u_execute (
        .op_i (op_bus),
        .ex_o (ex_bus)
    );

    mem_io_stage u_mem_io (
        .clk          (clk),
        .rstn_fpga    (rstn_fpga),
        .op_i         (op_bus),
        .ex_i         (ex_bus),
        .switch_i     (switch_i),
        .wb_o         (wb_bus),
        .led_o        (led_o),
        .led_strobe_o (led_strobe_o),
        .halted_o     (halted_o)
    );

endmodule

`default_nettype wire

// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 codes
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL     = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_WORD    = 3'b010;

    // funct7 codes, alt selects sub
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // imm field of ebreak in the system opcode
    localparam logic [11:0] SYS_EBREAK = 12'h001;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SLT    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

endpackage

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module tb_rv_core;

    localparam int RESET_CYCLES    = 8;
    localparam int MAX_PROG_WORDS  = 32;
    localparam int MAX_EXEC_CYCLES = 64;
    localparam int NUM_RUNS        = 12;
    // twice the worst case of every run
    localparam int TIMEOUT_CYCLES  =
        2 * NUM_RUNS * (RESET_CYCLES + MAX_PROG_WORDS + MAX_EXEC_CYCLES);

    localparam rv_isa_pkg::word_t LED_ADDR    = `CFG_IO_LED_ADDR;
    localparam rv_isa_pkg::word_t SWITCH_ADDR = `CFG_IO_SWITCH_ADDR;
    localparam rv_isa_pkg::word_t XOR_CONST   = 32'h0000_A5C3;
    localparam rv_isa_pkg::word_t EBREAK      = 32'h0010_0073;

    logic        clk;
    logic        rstn_fpga;
    logic        prog_we_i;
    logic [7:0]  prog_addr_i;
    logic [31:0] prog_data_i;
    logic [15:0] switch_i;
    logic [15:0] led_o;
    logic        led_strobe_o;
    logic        halted_o;

    rv_isa_pkg::word_t prog [$];
    logic [15:0]       exp_leds [$];
    logic [15:0]       led_seen [$];
    int                seen_base;
    rv_isa_pkg::word_t rng_state;
    int                errors;
    int                checks;
    int                late_strobes;
    int                cycle_count;

    rv_core_top uut (
        .clk          (clk),
        .rstn_fpga    (rstn_fpga),
        .prog_we_i    (prog_we_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .switch_i     (switch_i),
        .led_o        (led_o),
        .led_strobe_o (led_strobe_o),
        .halted_o     (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // instruction encoders
    // ------------------------------
    function automatic rv_isa_pkg::word_t r_type(input rv_isa_pkg::funct7_t f7,
        input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rd,
        input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic rv_isa_pkg::word_t i_type(input rv_isa_pkg::opcode_e opc,
        input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rd,
        input rv_isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t s_type(input rv_isa_pkg::reg_idx_t rs2,
        input rv_isa_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_WORD, imm[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic rv_isa_pkg::word_t b_type(input rv_isa_pkg::funct3_t f3,
        input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::reg_idx_t rs2,
        input logic [12:0] ofs);
        return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t u_type(input rv_isa_pkg::reg_idx_t rd,
        input logic [19:0] upper);
        return {upper, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    function automatic rv_isa_pkg::word_t j_type(input rv_isa_pkg::reg_idx_t rd,
        input logic [20:0] ofs);
        return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    function automatic rv_isa_pkg::word_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // signed order from the sign bits, then the magnitude order for equal signs
    function automatic rv_isa_pkg::word_t signed_less(input rv_isa_pkg::word_t a,
        input rv_isa_pkg::word_t b);
        if (a[31] != b[31]) begin
            return {31'b0, a[31]};
        end
        return {31'b0, a < b};
    endfunction

    // ------------------------------
    // program building
    // ------------------------------
    task automatic push_instr(input rv_isa_pkg::word_t instr);
        prog.push_back(instr);
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task automatic load_const(input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t value);
        rv_isa_pkg::word_t upper;
        rv_isa_pkg::word_t lower;
        upper = (value + 32'h800) >> 12;
        lower = value - (upper << 12);
        push_instr(u_type(rd, upper[19:0]));
        push_instr(i_type(rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::F3_ADD_SUB, rd, rd, lower[11:0]));
    endtask

    task automatic store_to_led(input rv_isa_pkg::reg_idx_t rs);
        push_instr(s_type(rs, 5'd0, LED_ADDR[11:0]));
    endtask

    task automatic read_switches(input rv_isa_pkg::reg_idx_t rd);
        push_instr(i_type(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_WORD, rd, 5'd0,
                          SWITCH_ADDR[11:0]));
    endtask

    task automatic expect_led(input rv_isa_pkg::word_t value);
        exp_leds.push_back(value[15:0]);
    endtask

    // ------------------------------
    // driving and checking
    // ------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp,
        input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // program goes in while reset is held and reset is released after it
    task automatic load_program();
        next_cycle();
        rstn_fpga = 1'b0;
        prog_we_i = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        for (int i = 0; i < prog.size(); i++) begin
            prog_we_i   = 1'b1;
            prog_addr_i = i[7:0];
            prog_data_i = prog[i];
            next_cycle();
        end
        prog_we_i = 1'b0;
        seen_base = led_seen.size();
        rstn_fpga = 1'b1;
        // outputs left over from the previous program must be cleared
        check_word({16'b0, led_o}, 32'd0, "led_o after reset");
        check_bit(led_strobe_o, 1'b0, "led_strobe_o after reset");
        check_bit(halted_o, 1'b0, "halted_o after reset");
    endtask

    task automatic wait_for_halt();
        int n;
        n = 0;
        while (!halted_o && n < MAX_EXEC_CYCLES) begin
            next_cycle();
            n++;
        end
        if (!halted_o) begin
            errors++;
            $display("core did not halt within %0d cycles at time %0t", n, $time);
        end
    endtask

    task automatic compare_leds(input string name);
        int n;
        n = led_seen.size() - seen_base;
        check_word(rv_isa_pkg::word_t'(n), rv_isa_pkg::word_t'(exp_leds.size()),
                   {name, " strobe count"});
        for (int i = 0; i < n && i < exp_leds.size(); i++) begin
            check_word({16'b0, led_seen[seen_base + i]}, {16'b0, exp_leds[i]},
                       $sformatf("%s led value %0d", name, i));
        end
    endtask

    // led values on strobe cycles
    always @(negedge clk) begin
        if (rstn_fpga && led_strobe_o) begin
            led_seen.push_back(led_o);
            if (halted_o) begin
                late_strobes++;
                $display("[ERROR] %0t: led strobe after halt, led_o %h", $time, led_o);
            end
        end
    end

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic check_reset_state();
        prog.delete();
        exp_leds.delete();
        load_program();
        repeat (4) next_cycle();
        check_bit(halted_o, 1'b0, "halted_o with empty program");
        compare_leds("empty program");
    endtask

    task automatic run_alu_ops();
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        a = xorshift32();
        b = xorshift32();
        prog.delete();
        exp_leds.delete();
        load_const(5'd1, a);
        load_const(5'd2, b);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SRL, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, 5'd3, 5'd1, 5'd2));
        store_to_led(5'd3);
        push_instr(EBREAK);
        expect_led(a + b);
        expect_led(a - b);
        expect_led(a & b);
        expect_led(a | b);
        expect_led(a ^ b);
        expect_led(a << b[4:0]);
        expect_led(a >> b[4:0]);
        expect_led(signed_less(a, b));
        load_program();
        wait_for_halt();
        compare_leds("alu");
    endtask

    // stores in one order and reads back in another
    task automatic run_data_memory();
        rv_isa_pkg::word_t vals [4];
        rv_isa_pkg::word_t ofs;
        int                order [4];
        order = '{2, 0, 3, 1};
        prog.delete();
        exp_leds.delete();
        for (int i = 0; i < 4; i++) begin
            vals[i] = xorshift32();
            ofs = 32'h40 + i * 4;
            load_const(5'd1, vals[i]);
            push_instr(s_type(5'd1, 5'd0, ofs[11:0]));
        end
        for (int k = 0; k < 4; k++) begin
            ofs = 32'h40 + order[k] * 4;
            push_instr(i_type(rv_isa_pkg::OPC_LOAD, rv_isa_pkg::F3_WORD, 5'd2, 5'd0, ofs[11:0]));
            store_to_led(5'd2);
            expect_led(vals[order[k]]);
        end
        push_instr(EBREAK);
        load_program();
        wait_for_halt();
        compare_leds("data memory");
    endtask

    task automatic run_sum_loop(input int n);
        prog.delete();
        exp_leds.delete();
        switch_i = n[15:0];
        read_switches(5'd1);
        push_instr(i_type(rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd2, 5'd0, 12'd0));
        push_instr(i_type(rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'd0));
        // loop head at 12
        push_instr(i_type(rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd3, 12'd1));
        push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 5'd2, 5'd2, 5'd3));
        push_instr(b_type(rv_isa_pkg::F3_BNE, 5'd3, 5'd1, 13'h1ff8));
        store_to_led(5'd2);
        push_instr(EBREAK);
        expect_led(n * (n + 1) / 2);
        load_program();
        wait_for_halt();
        compare_leds($sformatf("sum to %0d", n));
        check_bit(halted_o, 1'b1, "halted_o after sum loop");
    endtask

    task automatic run_jump_halt();
        rv_isa_pkg::word_t jal_addr;
        prog.delete();
        exp_leds.delete();
        push_instr(i_type(rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd1, 5'd0, 12'h05a));
        jal_addr = 32'd4;
        push_instr(j_type(5'd5, 21'd8));
        store_to_led(5'd1);
        store_to_led(5'd5);
        push_instr(EBREAK);
        // the frozen pc sits on this store once halted
        store_to_led(5'd1);
        expect_led(jal_addr + 32'd4);
        load_program();
        wait_for_halt();
        repeat (4) next_cycle();
        check_bit(halted_o, 1'b1, "halted_o stays high");
        check_bit(led_strobe_o, 1'b0, "led_strobe_o while halted");
        compare_leds("jump");
    endtask

    task automatic run_switch_xor(input int runs);
        rv_isa_pkg::word_t r;
        for (int k = 0; k < runs; k++) begin
            r = xorshift32();
            prog.delete();
            exp_leds.delete();
            switch_i = r[15:0];
            read_switches(5'd1);
            load_const(5'd2, XOR_CONST);
            push_instr(r_type(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 5'd3, 5'd1, 5'd2));
            store_to_led(5'd3);
            push_instr(EBREAK);
            expect_led({16'b0, r[15:0]} ^ XOR_CONST);
            load_program();
            wait_for_halt();
            compare_leds($sformatf("switch xor run %0d", k));
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: simulation still running after %0d cycles", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rv_isa_pkg::word_t r;
        rstn_fpga    = 1'b0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        switch_i     = '0;
        errors       = 0;
        checks       = 0;
        late_strobes = 0;
        seen_base    = 0;
        rng_state    = 32'd63738;

        check_reset_state();
        run_alu_ops();
        run_data_memory();
        r = xorshift32();
        run_sum_loop(int'(r % 32'd15) + 1);
        run_sum_loop(10);
        run_jump_halt();
        run_switch_xor(6);

        $display("checks: %0d, errors: %0d, strobes after halt: %0d",
                 checks, errors, late_strobes);
        if (errors == 0 && late_strobes == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
